// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    localparam int WORD_BITS   = 32;
    localparam int INDEX_BITS  = 2;
    localparam int OFFSET_BITS = 2;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = WORD_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int LINE_WORDS  = 2 ** OFFSET_BITS;

    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

    // byte address as seen by the fetch unit
    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic                 addr_ok;
        logic                 data_ok;
        logic [WORD_BITS-1:0] data;
    } ibus_resp_t;

    // valid is held for the whole burst
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } cbus_req_t;

    typedef struct packed {
        logic                 okay;
        logic                 last;
        logic [WORD_BITS-1:0] rdata;
    } cbus_resp_t;

    // what the refill stage tells the rest of the cache
    typedef struct packed {
        logic                  busy;
        tag_t                  tag;
        index_t                index;
        logic [LINE_WORDS-1:0] ready;
    } refill_state_t;

endpackage

// ==== rtl/plru_select.sv ====
module plru_select #(
    parameter int  NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic [NUM_WAYS-2:0] tree,
    input  logic [WAY_BITS-1:0] touch_way,
    output logic [WAY_BITS-1:0] victim_way,
    output logic [NUM_WAYS-2:0] new_tree
);

    // heap layout, node n has children 2n+1 and 2n+2
    // a tree bit of 0 points the victim search to the left subtree
    always_comb begin
        int node;
        node = 0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = tree[node];
            node = 2 * node + 1 + int'(tree[node]);
        end
    end

    // every node on the touched path now points away from it
    always_comb begin
        int node;
        node = 0;
        new_tree = tree;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            new_tree[node] = ~touch_way[WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
        end
    end

endmodule

// ==== rtl/tag_lookup.sv ====
module tag_lookup #(
    parameter int  NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clk,
    input  logic                resetn,
    input  icache_pkg::addr_t   addr,
    input  logic                accept_hit,
    input  logic                start_miss,
    output logic                hit,
    output logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0] victim_way
);
    import icache_pkg::*;

    localparam int NUM_SETS = 2 ** INDEX_BITS;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-2:0] tree_q  [NUM_SETS];

    logic [NUM_WAYS-1:0] hit_bits;
    logic [WAY_BITS-1:0] touch_way;
    logic [NUM_WAYS-2:0] new_tree;

    // all ways of the set compared at once
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign hit_bits[w] = valid_q[addr.index][w] && (tag_q[addr.index][w] == addr.tag);
    end

    assign hit = |hit_bits;

    // one-hot to way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_bits[w]) begin
                hit_way = hit_way | WAY_BITS'(w);
            end
        end
    end

    // a fresh install becomes most recently used
    assign touch_way = start_miss ? victim_way : hit_way;

    plru_select #(
        .NUM_WAYS(NUM_WAYS)
    ) u_plru (
        .tree      (tree_q[addr.index]),
        .touch_way (touch_way),
        .victim_way(victim_way),
        .new_tree  (new_tree)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                tree_q[s]  <= '0;
            end
        end else begin
            if (start_miss) begin
                valid_q[addr.index][victim_way] <= 1'b1;
            end
            if (start_miss || accept_hit) begin
                tree_q[addr.index] <= new_tree;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            tag_q[addr.index][victim_way] <= addr.tag;
        end
    end

    // installs only happen on a miss, so a set never holds a tag twice
    a_hit_onehot : assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_bits));

endmodule

// ==== rtl/line_refill.sv ====
module line_refill #(
    parameter int  NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             start_miss,
    input  icache_pkg::addr_t                addr,
    input  logic [WAY_BITS-1:0]              victim_way,
    input  icache_pkg::cbus_resp_t           cbus_resp,
    output icache_pkg::cbus_req_t            cbus_req,
    output logic                             miss_avail,
    output icache_pkg::refill_state_t        state,
    output logic                             wr_en,
    output logic [WAY_BITS-1:0]              wr_way,
    output icache_pkg::offset_t              wr_offset,
    output logic [icache_pkg::WORD_BITS-1:0] wr_data
);
    import icache_pkg::*;

    logic                  busy_q;
    offset_t               count_q;
    logic [LINE_WORDS-1:0] ready_q;
    tag_t                  tag_q;
    index_t                index_q;
    logic [WAY_BITS-1:0]   way_q;
    logic                  last_beat;

    assign last_beat  = cbus_resp.okay && cbus_resp.last;
    // next miss may start in the cycle of the final beat
    assign miss_avail = !busy_q || last_beat;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            ready_q <= '0;
        end else begin
            if (cbus_resp.okay) begin
                ready_q[count_q] <= 1'b1;
                count_q          <= count_q + 1'b1;
            end
            if (last_beat) begin
                busy_q <= 1'b0;
            end
            // a new burst always begins at word 0
            if (start_miss) begin
                busy_q  <= 1'b1;
                count_q <= '0;
                ready_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            tag_q   <= addr.tag;
            index_q <= addr.index;
            way_q   <= victim_way;
        end
    end

    assign cbus_req.valid       = busy_q;
    assign cbus_req.addr.tag    = tag_q;
    assign cbus_req.addr.index  = index_q;
    assign cbus_req.addr.offset = '0;
    assign cbus_req.addr.align  = '0;

    assign state.busy  = busy_q;
    assign state.tag   = tag_q;
    assign state.index = index_q;
    assign state.ready = ready_q;

    // each beat goes straight into the data array
    assign wr_en     = cbus_resp.okay && busy_q;
    assign wr_way    = way_q;
    assign wr_offset = count_q;
    assign wr_data   = cbus_resp.rdata;

    a_okay_busy : assert property (@(posedge clk) disable iff (resetn)
        cbus_resp.okay |-> busy_q);

    a_last_fourth : assert property (@(posedge clk) disable iff (resetn)
        cbus_resp.last |-> cbus_resp.okay && count_q == offset_t'(LINE_WORDS - 1));

endmodule

// ==== rtl/icache_data_ram.sv ====
module icache_data_ram #(
    parameter int  NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                             clk,
    input  logic [WAY_BITS-1:0]              rd_way,
    input  icache_pkg::index_t               rd_index,
    input  icache_pkg::offset_t              rd_offset,
    input  logic                             wr_en,
    input  logic [WAY_BITS-1:0]              wr_way,
    input  icache_pkg::index_t               wr_index,
    input  icache_pkg::offset_t              wr_offset,
    input  logic [icache_pkg::WORD_BITS-1:0] wr_data,
    output logic [icache_pkg::WORD_BITS-1:0] rd_data
);
    import icache_pkg::*;

    localparam int DEPTH = NUM_WAYS * (2 ** (INDEX_BITS + OFFSET_BITS));

    logic [WORD_BITS-1:0] mem [DEPTH];

    // read sees the old word when both ports hit the same entry
    always_ff @(posedge clk) begin
        rd_data <= mem[{rd_way, rd_index, rd_offset}];
        if (wr_en) begin
            mem[{wr_way, wr_index, wr_offset}] <= wr_data;
        end
    end

endmodule

// ==== rtl/fetch_respond.sv ====
module fetch_respond #(
    parameter int  NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  icache_pkg::ibus_req_t            ibus_req,
    input  logic                             hit,
    input  logic [WAY_BITS-1:0]              hit_way,
    input  logic                             miss_avail,
    input  icache_pkg::refill_state_t        state,
    input  logic [icache_pkg::WORD_BITS-1:0] rd_data,
    output icache_pkg::ibus_resp_t           ibus_resp,
    output logic                             accept_hit,
    output logic                             start_miss,
    output logic [WAY_BITS-1:0]              rd_way,
    output icache_pkg::index_t               rd_index,
    output icache_pkg::offset_t              rd_offset
);
    import icache_pkg::*;

    addr_t addr;
    logic  in_refill;
    logic  word_ready;
    logic  data_ok_q;

    assign addr = ibus_req.addr;

    // tag already installed, so the line hits before its words arrive
    assign in_refill  = state.busy && addr.tag == state.tag && addr.index == state.index;
    assign word_ready = !in_refill || state.ready[addr.offset];

    assign accept_hit = ibus_req.req && hit && word_ready;
    assign start_miss = ibus_req.req && !hit && miss_avail;

    assign rd_way    = hit_way;
    assign rd_index  = addr.index;
    assign rd_offset = addr.offset;

    // hit stage
    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept_hit;
        end
    end

    assign ibus_resp.addr_ok = accept_hit;
    assign ibus_resp.data_ok = data_ok_q;
    assign ibus_resp.data    = rd_data;

    // a waiting request keeps its address until addr_ok
    a_req_held : assert property (@(posedge clk) disable iff (resetn)
        ibus_req.req && !ibus_resp.addr_ok |=> ibus_req.req && $stable(ibus_req.addr));

endmodule

// ==== rtl/icache.sv ====
module icache #(
    parameter int NUM_WAYS = 4
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::ibus_req_t  ibus_req,
    input  icache_pkg::cbus_resp_t cbus_resp,
    output icache_pkg::ibus_resp_t ibus_resp,
    output icache_pkg::cbus_req_t  cbus_req
);
    import icache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    logic                 hit;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  victim_way;
    logic                 accept_hit;
    logic                 start_miss;
    logic                 miss_avail;
    refill_state_t        state;
    logic                 wr_en;
    logic [WAY_BITS-1:0]  wr_way;
    offset_t              wr_offset;
    logic [WORD_BITS-1:0] wr_data;
    logic [WAY_BITS-1:0]  rd_way;
    index_t               rd_index;
    offset_t              rd_offset;
    logic [WORD_BITS-1:0] rd_data;

    tag_lookup #(
        .NUM_WAYS(NUM_WAYS)
    ) u_tag_lookup (
        .clk       (clk),
        .resetn    (resetn),
        .addr      (ibus_req.addr),
        .accept_hit(accept_hit),
        .start_miss(start_miss),
        .hit       (hit),
        .hit_way   (hit_way),
        .victim_way(victim_way)
    );

    line_refill #(
        .NUM_WAYS(NUM_WAYS)
    ) u_line_refill (
        .clk       (clk),
        .resetn    (resetn),
        .start_miss(start_miss),
        .addr      (ibus_req.addr),
        .victim_way(victim_way),
        .cbus_resp (cbus_resp),
        .cbus_req  (cbus_req),
        .miss_avail(miss_avail),
        .state     (state),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_offset (wr_offset),
        .wr_data   (wr_data)
    );

    // refill writes go to the set held in the refill state
    icache_data_ram #(
        .NUM_WAYS(NUM_WAYS)
    ) u_data_ram (
        .clk      (clk),
        .rd_way   (rd_way),
        .rd_index (rd_index),
        .rd_offset(rd_offset),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_index (state.index),
        .wr_offset(wr_offset),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

    fetch_respond #(
        .NUM_WAYS(NUM_WAYS)
    ) u_fetch_respond (
        .clk       (clk),
        .resetn    (resetn),
        .ibus_req  (ibus_req),
        .hit       (hit),
        .hit_way   (hit_way),
        .miss_avail(miss_avail),
        .state     (state),
        .rd_data   (rd_data),
        .ibus_resp (ibus_resp),
        .accept_hit(accept_hit),
        .start_miss(start_miss),
        .rd_way    (rd_way),
        .rd_index  (rd_index),
        .rd_offset (rd_offset)
    );

endmodule

// ==== test/tb_icache.sv ====
module tb_icache;
    import icache_pkg::*;

    localparam int NUM_REQS = 1500;
    localparam int TIMEOUT  = NUM_REQS * 40;

    logic       clk = 1'b0;
    logic       resetn;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    logic [31:0] lfsr;
    int          cycles = 0;
    int          issued = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        accepted = 1'b0;
    logic        pending = 1'b0;
    logic        done = 1'b0;
    int          beat = 0;
    int          gap = 0;

    // reference cache, four ways per set
    logic [3:0]  m_valid [4];
    tag_t        m_tag   [4][4];
    logic [2:0]  m_tree  [4];
    logic        m_busy = 1'b0;
    int          m_beats = 0;
    addr_t       m_line = '0;
    logic [31:0] exp_q [$];

    icache dut (
        .clk      (clk),
        .resetn   (resetn),
        .ibus_req (ibus_req),
        .cbus_resp(cbus_resp),
        .ibus_resp(ibus_resp),
        .cbus_req (cbus_req)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] mem_word(logic [31:0] a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic addr_t pool_addr(logic [2:0] k, offset_t off);
        addr_t a;
        // six lines share set 1, more than its four ways
        a.tag    = tag_t'(k) * tag_t'(7) + tag_t'(5);
        a.index  = (k < 3'd6) ? index_t'(1) : index_t'(2);
        a.offset = off;
        a.align  = '0;
        return a;
    endfunction

    // root bit picks the half, the lower bit the way inside it
    function automatic logic [1:0] plru_victim(logic [2:0] t);
        if (t[0]) begin
            return {1'b1, t[2]};
        end
        return {1'b0, t[1]};
    endfunction

    function automatic logic [2:0] plru_touch(logic [2:0] t, logic [1:0] w);
        logic [2:0] n;
        n = t;
        n[0] = ~w[1];
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    task automatic find_line(input addr_t a, output logic hit, output logic [1:0] way);
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
    endtask

    task automatic check_resp(input ibus_resp_t got, input ibus_resp_t exp);
        if (got.addr_ok !== exp.addr_ok) begin
            value_errors++;
            $display("Fail %0t: addr_ok is %b, expected %b", $time, got.addr_ok, exp.addr_ok);
        end
        if (got.data_ok !== exp.data_ok) begin
            value_errors++;
            $display("Fail %0t: data_ok is %b, expected %b", $time, got.data_ok, exp.data_ok);
        end else if (exp.data_ok && got.data !== exp.data) begin
            value_errors++;
            $display("Fail %0t: data is %h, expected %h", $time, got.data, exp.data);
        end
    endtask

    task automatic check_cbus(input cbus_req_t got, input cbus_req_t exp);
        if (got.valid !== exp.valid) begin
            value_errors++;
            $display("Fail %0t: cbus valid is %b, expected %b", $time, got.valid, exp.valid);
        end else if (exp.valid && got.addr !== exp.addr) begin
            value_errors++;
            $display("Fail %0t: cbus addr is %h, expected %h", $time, got.addr, exp.addr);
        end
    endtask

    // hold the request until it is accepted, then maybe issue the next one
    task automatic drive_fetch();
        logic [31:0] r;
        if (!ibus_req.req || accepted) begin
            ibus_req.req = 1'b0;
            if (issued < NUM_REQS) begin
                take_bits(2, r);
                if (r[1:0] != 2'b00) begin
                    take_bits(5, r);
                    ibus_req.addr = pool_addr(r[4:2], r[1:0]);
                    ibus_req.req  = 1'b1;
                    issued++;
                end
            end
        end
    endtask

    // memory side, one beat after a random gap of 0 to 3 cycles
    task automatic drive_memory();
        logic [31:0] r;
        cbus_resp = '0;
        if (cbus_req.valid) begin
            if (gap > 0) begin
                gap--;
            end else begin
                cbus_resp.okay  = 1'b1;
                cbus_resp.last  = (beat == 3);
                cbus_resp.rdata = mem_word(32'(cbus_req.addr) + 32'(beat * 4));
                beat = (beat + 1) % 4;
                take_bits(2, r);
                gap = int'(r[1:0]);
            end
        end
    endtask

    // checks at the falling edge, where inputs and outputs are settled
    always @(negedge clk) begin
        ibus_resp_t exp_resp;
        cbus_req_t  exp_cbus;
        addr_t      a;
        logic       lhit;
        logic [1:0] lway;
        logic [1:0] vway;
        logic       in_line;
        logic       beat_last;
        cycles++;
        a = ibus_req.addr;
        find_line(a, lhit, lway);
        in_line   = m_busy && a.tag == m_line.tag && a.index == m_line.index;
        beat_last = cbus_resp.okay && cbus_resp.last;
        exp_resp = '0;
        exp_resp.addr_ok = ibus_req.req && lhit && (!in_line || int'(a.offset) < m_beats);
        exp_resp.data_ok = pending;
        if (pending && exp_q.size() > 0) begin
            exp_resp.data = exp_q.pop_front();
        end
        if (ibus_resp.data_ok && !pending) begin
            other_errors++;
            $display("data_ok at time %0t with no accepted request before it", $time);
            exp_resp.data_ok = 1'b1;
            exp_resp.data    = ibus_resp.data;
        end
        check_resp(ibus_resp, exp_resp);
        exp_cbus = '0;
        exp_cbus.valid = m_busy;
        exp_cbus.addr  = m_line;
        check_cbus(cbus_req, exp_cbus);
        accepted = ibus_req.req && ibus_resp.addr_ok;
        pending  = exp_resp.addr_ok;
        if (exp_resp.addr_ok) begin
            exp_q.push_back(mem_word(32'(a)));
            m_tree[a.index] = plru_touch(m_tree[a.index], lway);
        end
        if (cbus_resp.okay) begin
            m_beats++;
        end
        if (beat_last) begin
            m_busy = 1'b0;
        end
        // busy already dropped here when this cycle carries last
        if (ibus_req.req && !lhit && !m_busy) begin
            vway = plru_victim(m_tree[a.index]);
            m_valid[a.index][vway] = 1'b1;
            m_tag[a.index][vway]   = a.tag;
            m_tree[a.index] = plru_touch(m_tree[a.index], vway);
            m_busy  = 1'b1;
            m_beats = 0;
            m_line  = a;
            m_line.offset = '0;
            m_line.align  = '0;
        end
    end

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        lfsr      = 32'h32be;
        resetn    = 1'b1;
        ibus_req  = '0;
        cbus_resp = '0;
        for (int s = 0; s < 4; s++) begin
            m_valid[s] = '0;
            m_tree[s]  = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            drive_fetch();
            drive_memory();
            if (issued == NUM_REQS && !ibus_req.req && !pending) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            other_errors++;
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
        end
        finish_run();
    end

endmodule

// ==== tb.f ====
rtl/icache_pkg.sv
rtl/plru_select.sv
rtl/tag_lookup.sv
rtl/line_refill.sv
rtl/icache_data_ram.sv
rtl/fetch_respond.sv
rtl/icache.sv
test/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_icache -o tb_icache_sim \
    && ./obj_dir/tb_icache_sim | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
